/* design/pw_usb_pkg.sv */
`default_nettype none

//////////////////////////////
// front-end receive side
//////////////////////////////

package pw_usb_pkg;

   // timestamp counts fe_clk cycles from the arming edge
   localparam int TIMESTAMP_W = 16;

   // one byte as delivered by the UTMI front end
   typedef logic [7:0] fe_byte_t;

   // saturates at all ones, never wraps
   typedef logic [TIMESTAMP_W-1:0] timestamp_t;

   // UTMI receive signals, sampled on fe_clk
   // a byte is taken when rxvalid and rxactive are both high
   typedef struct packed {
      fe_byte_t data;     // received byte
      logic     rxvalid;  // data holds a byte this cycle
      logic     rxactive; // packet in progress
      logic     rxerror;  // front end flagged a receive error
   } fe_rx_t;

   //////////////////////////////
   // capture output
   //////////////////////////////

   // one record per captured byte
   typedef struct packed {
      timestamp_t timestamp; // cycles since arming, minus one
      fe_byte_t   data;      // the byte itself
      logic       err;       // rxerror seen with this byte
   } cap_rec_t;

   // record layout, msb first:
   //    [24:9] timestamp
   //    [8:1]  data
   //    [0]    err

endpackage

`default_nettype wire

/* design/pw_trig_pkg.sv */
`default_nettype none

//////////////////////////////
// pattern and trigger setup
//////////////////////////////

package pw_trig_pkg;

   localparam int PATTERN_BYTES = 8;
   localparam int PATTERN_W     = PATTERN_BYTES * 8;
   localparam int PAT_CNT_W     = 4;  // holds 1..PATTERN_BYTES
   localparam int TRIG_DELAY_W  = 20;
   localparam int TRIG_WIDTH_W  = 17;
   localparam int CAP_LEN_W     = 12;

   // byte 0 sits in bits 7..0 and meets the first packet byte
   typedef logic [PATTERN_W-1:0]    pattern_t;
   typedef logic [PAT_CNT_W-1:0]    pat_cnt_t;
   typedef logic [TRIG_DELAY_W-1:0] trig_delay_t;
   typedef logic [TRIG_WIDTH_W-1:0] trig_width_t; // at least 1
   typedef logic [CAP_LEN_W-1:0]    cap_len_t;

   // static setup, held while armed
   typedef struct packed {
      pattern_t    pattern;
      pattern_t    mask;          // 1 = bit is compared
      pat_cnt_t    pattern_bytes;
      trig_delay_t trig_delay;    // cycles between match and pulse
      trig_width_t trig_width;    // pulse length in cycles
      cap_len_t    cap_len;       // records per arm
   } pw_cfg_t;

   // trigger sequencer
   typedef enum logic [2:0] {
      IDLE,
      ARMED,
      DELAY,
      PULSE,
      DONE
   } trig_state_e;

endpackage

`default_nettype wire

/* design/pw_pattern_matcher.sv */
`timescale 1ns/1ps
`default_nettype none

module pw_pattern_matcher (
   input  wire                   fe_clk,
   input  wire                   rst_n_i,
   input  wire pw_usb_pkg::fe_rx_t     fe_rx_i,
   input  wire pw_trig_pkg::pattern_t  pattern_i,
   input  wire pw_trig_pkg::pattern_t  mask_i,
   input  wire pw_trig_pkg::pat_cnt_t  pattern_bytes_i,
   output logic                  match_o
);

   import pw_usb_pkg::*;
   import pw_trig_pkg::*;

   pat_cnt_t   idx_q;      // byte position in current packet
   logic       hit_q;      // all compared bytes matched so far
   logic [2:0] sel;
   fe_byte_t   pat_byte;
   fe_byte_t   mask_byte;
   logic       accept;
   logic       in_pattern;
   logic       last_byte;
   logic       byte_ok;

   assign accept     = fe_rx_i.rxvalid && fe_rx_i.rxactive;
   assign in_pattern = idx_q < pattern_bytes_i;
   assign last_byte  = idx_q == pat_cnt_t'(pattern_bytes_i - 1'b1);

   // pick the pattern byte for this position
   assign sel       = idx_q[2:0];
   assign pat_byte  = pattern_i[sel*8 +: 8];
   assign mask_byte = mask_i[sel*8 +: 8];

   // masked-off bits never cause a miss, an rx error always does
   assign byte_ok = (((fe_rx_i.data ^ pat_byte) & mask_byte) == '0) && !fe_rx_i.rxerror;

   //////////////////////////////
   // per-packet compare
   //////////////////////////////

   always_ff @(posedge fe_clk) begin
      if (!rst_n_i) begin
         idx_q   <= '0;
         hit_q   <= 1'b1;
         match_o <= 1'b0;
      end else begin
         match_o <= 1'b0; // strobe
         if (!fe_rx_i.rxactive) begin
            // between packets, start over
            idx_q <= '0;
            hit_q <= 1'b1;
         end else if (accept && in_pattern) begin
            idx_q <= idx_q + 1'b1; // stops at pattern_bytes, rest ignored
            if (!byte_ok)
               hit_q <= 1'b0;
            if (last_byte && hit_q && byte_ok)
               match_o <= 1'b1;
         end
      end
   end

   // setup must name at least one and at most all pattern bytes
   a_pat_cnt_range: assert property (@(posedge fe_clk) disable iff (!rst_n_i)
      accept |-> pattern_bytes_i inside {[1:PATTERN_BYTES]});

endmodule

`default_nettype wire

/* design/pw_fe_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module pw_fe_capture (
   input  wire                   fe_clk,
   input  wire                   rst_n_i,
   input  wire                   capturing_i,
   input  wire pw_usb_pkg::fe_rx_t     fe_rx_i,
   input  wire pw_trig_pkg::cap_len_t  cap_len_i,
   output logic                  cap_valid_o,
   output pw_usb_pkg::cap_rec_t  cap_rec_o
);

   import pw_usb_pkg::*;
   import pw_trig_pkg::*;

   timestamp_t ts_q;       // cycles since capturing went high
   cap_len_t   rec_cnt_q;  // records produced this arm
   cap_rec_t   rec_q;      // record held one cycle before output
   logic       take_q;
   logic       accept;
   logic       take;
   logic       ts_full;

   assign accept  = fe_rx_i.rxvalid && fe_rx_i.rxactive;
   assign ts_full = ts_q == {TIMESTAMP_W{1'b1}};

   // record only while armed and below the length limit
   assign take = accept && capturing_i && (rec_cnt_q < cap_len_i);

   //////////////////////////////
   // timestamp and record count
   //////////////////////////////

   always_ff @(posedge fe_clk) begin
      if (!rst_n_i) begin
         ts_q        <= '0;
         rec_cnt_q   <= '0;
         take_q      <= 1'b0;
         cap_valid_o <= 1'b0;
      end else begin
         take_q      <= take;
         cap_valid_o <= take_q; // one cycle after the byte was taken
         if (!capturing_i) begin
            ts_q      <= '0;
            rec_cnt_q <= '0;
         end else begin
            if (!ts_full)
               ts_q <= ts_q + 1'b1; // hold at max
            if (take)
               rec_cnt_q <= rec_cnt_q + 1'b1;
         end
      end
   end

   // record payload, qualified by cap_valid_o
   always_ff @(posedge fe_clk) begin
      if (take) begin
         rec_q.timestamp <= ts_q;
         rec_q.data      <= fe_rx_i.data;
         rec_q.err       <= fe_rx_i.rxerror;
      end
      if (take_q)
         cap_rec_o <= rec_q;
   end

   // record count never runs past the limit within one arm
   a_cap_limit: assert property (@(posedge fe_clk) disable iff (!rst_n_i)
      capturing_i |-> rec_cnt_q <= cap_len_i);

endmodule

`default_nettype wire

/* design/pw_trigger_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module pw_trigger_timer (
   input  wire                      fe_clk,
   input  wire                      rst_n_i,
   input  wire                      load_i,
   input  wire pw_trig_pkg::trig_width_t  count_i,
   output logic                     done_o
);

   import pw_trig_pkg::*;

   trig_width_t cnt_q;
   logic        busy_q;

   // high for one cycle once a loaded count has run down
   assign done_o = busy_q && (cnt_q == '0);

   always_ff @(posedge fe_clk) begin
      if (!rst_n_i) begin
         cnt_q  <= '0;
         busy_q <= 1'b0;
      end else if (load_i) begin
         cnt_q  <= count_i; // restart, even mid count
         busy_q <= 1'b1;
      end else if (busy_q) begin
         if (cnt_q == '0)
            busy_q <= 1'b0; // done seen this edge
         else
            cnt_q <= cnt_q - 1'b1;
      end
   end

   // done comes straight from a zero load or from a running count
   a_done_after_load: assert property (@(posedge fe_clk) disable iff (!rst_n_i)
      done_o |-> $past(load_i) || $past(busy_q && (cnt_q != '0)));

endmodule

`default_nettype wire

/* design/pw_trigger_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module pw_trigger_fsm (
   input  wire                      fe_clk,
   input  wire                      rst_n_i,
   input  wire                      arm_i,
   input  wire                      match_i,
   input  wire                      timer_done_i,
   input  wire pw_trig_pkg::trig_delay_t  trig_delay_i,
   input  wire pw_trig_pkg::trig_width_t  trig_width_i,
   output logic                     timer_load_o,
   output pw_trig_pkg::trig_width_t timer_count_o,
   output logic                     trig_o,
   output logic                     capturing_o
);

   import pw_trig_pkg::*;

   trig_state_e state_q;
   trig_state_e state_d;

   //////////////////////////////
   // next state
   //////////////////////////////

   always_comb begin
      state_d       = state_q;
      timer_load_o  = 1'b0;
      timer_count_o = trig_width_i - 1'b1;
      if (!arm_i) begin
         state_d = IDLE; // disarm wins in every state
      end else begin
         case (state_q)
            IDLE: begin
               state_d = ARMED;
            end
            ARMED: begin
               if (match_i) begin
                  timer_load_o = 1'b1;
                  if (trig_delay_i == '0) begin
                     state_d = PULSE; // no delay stage
                  end else begin
                     state_d       = DELAY;
                     timer_count_o = trig_width_t'(trig_delay_i - 1'b1);
                  end
               end
            end
            DELAY: begin
               if (timer_done_i) begin
                  state_d      = PULSE;
                  timer_load_o = 1'b1; // width count
               end
            end
            PULSE: begin
               if (timer_done_i)
                  state_d = DONE;
            end
            DONE: begin
               state_d = DONE; // one trigger per arm
            end
            default: begin
               state_d = IDLE;
            end
         endcase
      end
   end

   //////////////////////////////
   // state and outputs
   //////////////////////////////

   always_ff @(posedge fe_clk) begin
      if (!rst_n_i) begin
         state_q     <= IDLE;
         trig_o      <= 1'b0;
         capturing_o <= 1'b0;
      end else begin
         state_q     <= state_d;
         trig_o      <= state_q == PULSE; // one cycle behind the state
         capturing_o <= state_d != IDLE;  // high from the arming edge
      end
   end

   a_width_nonzero: assert property (@(posedge fe_clk) disable iff (!rst_n_i)
      state_q == ARMED |-> trig_width_i != '0);

   // no pulse while still waiting for a match or for the delay
   a_trig_in_pulse: assert property (@(posedge fe_clk) disable iff (!rst_n_i)
      trig_o |-> !(state_q inside {ARMED, DELAY}));

endmodule

`default_nettype wire

/* design/pw_sniffer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pw_sniffer_top (
   input  wire                    fe_clk,
   input  wire                    rst_n_i,
   input  wire                    arm_i,
   input  wire pw_trig_pkg::pw_cfg_t    cfg_i,
   input  wire pw_usb_pkg::fe_rx_t      fe_rx_i,
   output logic                   trig_o,
   output logic                   capturing_o,
   output logic                   cap_valid_o,
   output pw_usb_pkg::cap_rec_t   cap_rec_o
);

   import pw_trig_pkg::*;

   logic        match;
   logic        timer_load;
   trig_width_t timer_count;
   logic        timer_done;

   //////////////////////////////
   // packet matching
   //////////////////////////////

   pw_pattern_matcher u_pattern_matcher (
      .fe_clk          (fe_clk),
      .rst_n_i         (rst_n_i),
      .fe_rx_i         (fe_rx_i),
      .pattern_i       (cfg_i.pattern),
      .mask_i          (cfg_i.mask),
      .pattern_bytes_i (cfg_i.pattern_bytes),
      .match_o         (match)
   );

   pw_fe_capture u_fe_capture (
      .fe_clk      (fe_clk),
      .rst_n_i     (rst_n_i),
      .capturing_i (capturing_o), // capture window follows arming
      .fe_rx_i     (fe_rx_i),
      .cap_len_i   (cfg_i.cap_len),
      .cap_valid_o (cap_valid_o),
      .cap_rec_o   (cap_rec_o)
   );

   //////////////////////////////
   // trigger generation
   //////////////////////////////

   pw_trigger_timer u_trigger_timer (
      .fe_clk  (fe_clk),
      .rst_n_i (rst_n_i),
      .load_i  (timer_load),
      .count_i (timer_count),
      .done_o  (timer_done)
   );

   pw_trigger_fsm u_trigger_fsm (
      .fe_clk        (fe_clk),
      .rst_n_i       (rst_n_i),
      .arm_i         (arm_i),
      .match_i       (match),
      .timer_done_i  (timer_done),
      .trig_delay_i  (cfg_i.trig_delay),
      .trig_width_i  (cfg_i.trig_width),
      .timer_load_o  (timer_load),
      .timer_count_o (timer_count),
      .trig_o        (trig_o),
      .capturing_o   (capturing_o)
   );

endmodule

`default_nettype wire

/* verification/tb_pw_sniffer_tests.svh */
`ifndef TB_PW_SNIFFER_TESTS_SVH
`define TB_PW_SNIFFER_TESTS_SVH

// rise after edge E+2+delay, then width cycles high
task automatic check_trigger(input int delay, input int width);
   int n;
   int high;
   n = 0;
   while (trig !== 1'b1 && n < WAIT_MAX) begin
      @(negedge fe_clk);
      n++;
   end
   if (trig !== 1'b1) begin
      report_timeout("trig_o to rise");
   end else begin
      check_count("trigger latency", cyc - last_pat_edge, delay + 2);
      high = 0;
      while (trig === 1'b1 && high < WAIT_MAX) begin
         @(negedge fe_clk);
         high++;
      end
      if (trig === 1'b1)
         report_timeout("trig_o to fall");
      else
         check_count("trigger width", high, width);
   end
endtask

task automatic check_quiet(input int cycles);
   logic seen;
   seen = 1'b0;
   repeat (cycles) begin
      @(negedge fe_clk);
      seen = seen | trig;
   end
   check_bit("trig_o in quiet window", seen, 1'b0);
endtask

task automatic compare_records;
   int n;
   n = 0;
   while (got_q.size() < exp_q.size() && n < WAIT_MAX) begin
      @(negedge fe_clk);
      n++;
   end
   if (got_q.size() < exp_q.size())
      report_timeout("all capture records");
   idle_cycles(4); // room for stray records
   check_count("record count", got_q.size(), exp_q.size());
   for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      check_rec(i, got_q[i], exp_q[i]);
      check_count("record cycle", got_cyc_q[i], exp_cyc_q[i]);
   end
endtask

//////////////////////////////
// directed tests
//////////////////////////////

task automatic test_reset_arm;
   check_bit("trig_o after reset", trig, 1'b0);
   check_bit("capturing_o after reset", capturing, 1'b0);
   check_bit("cap_valid_o after reset", cap_valid, 1'b0);
   setup_cfg('1, 4, 5, 3, 16);
   set_arm(1'b1);
   idle_cycles(3);
   check_bit("capturing_o while armed", capturing, 1'b1);
   set_arm(1'b0);
   idle_cycles(2);
   check_bit("capturing_o after disarm", capturing, 1'b0);
endtask

task automatic test_trigger_timing;
   setup_cfg('1, 4, 5, 3, 64);
   set_arm(1'b1);
   build_packet(4);
   send_packet(4, 4);
   check_trigger(5, 3);
   set_arm(1'b0);
   setup_cfg('1, 4, 0, 3, 64); // no delay stage
   set_arm(1'b1);
   build_packet(4);
   send_packet(4, 4);
   check_trigger(0, 3);
   set_arm(1'b0);
endtask

task automatic test_mask_error;
   setup_cfg(64'h0000_0000_e7ff_7f3c, 4, 3, 2, 64);
   set_arm(1'b1);
   build_packet(4);      // masked-off bits are random
   send_packet(4, 4);
   check_trigger(3, 2);
   set_arm(1'b0);
   set_arm(1'b1);
   build_packet(4);
   pkt_byte[2] = pkt_byte[2] ^ 8'h10; // compared bit
   send_packet(4, 4);
   check_quiet(3 + 2 + 10);
   build_packet(4);
   pkt_err[1] = 1'b1;
   send_packet(4, 4);
   check_quiet(3 + 2 + 10);
   set_arm(1'b0);
endtask

task automatic test_one_per_arm;
   setup_cfg('1, 3, 2, 4, 64);
   set_arm(1'b1);
   build_packet(3);
   send_packet(3, 3);
   check_trigger(2, 4);
   build_packet(3);      // now in DONE
   send_packet(3, 3);
   check_quiet(2 + 4 + 10);
   set_arm(1'b0);
   build_packet(3);      // disarmed
   send_packet(3, 3);
   check_quiet(2 + 4 + 10);
   set_arm(1'b1);
   build_packet(3);
   send_packet(3, 3);
   check_trigger(2, 4);
   set_arm(1'b0);
endtask

// 13 bytes offered against a limit of 10
task automatic test_capture;
   setup_cfg('1, 2, 1, 1, 10);
   set_arm(1'b1);
   idle_cycles(3);
   build_packet(6);
   pkt_err[3] = 1'b1;
   pkt_err[5] = 1'b1;
   send_packet(6, 2);
   idle_cycles(2);
   build_packet(7);
   pkt_err[6] = 1'b1;
   send_packet(7, 2);
   compare_records();
   check_count("records per arm", got_q.size(), 10);
   set_arm(1'b0);
endtask

`endif

/* verification/tb_pw_sniffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pw_sniffer;

   import pw_usb_pkg::*;
   import pw_trig_pkg::*;

   localparam int WAIT_MAX = 1000; // cycles allowed per wait

   logic     fe_clk;
   logic     rst_n;
   logic     arm;
   pw_cfg_t  cfg;
   fe_rx_t   fe_rx;
   logic     trig;
   logic     capturing;
   logic     cap_valid;
   cap_rec_t cap_rec;

   int          cyc = 0;        // rising edges so far
   int          err_cnt;
   int          chk_cnt;
   logic        model_armed;    // expected capture window
   int          arm_edge;
   int          model_recs;
   int          last_pat_edge;  // edge that took the last pattern byte
   cap_rec_t    exp_q[$];
   cap_rec_t    got_q[$];
   int          exp_cyc_q[$];
   int          got_cyc_q[$];
   fe_byte_t    pkt_byte [32];
   logic        pkt_err  [32];

   pw_sniffer_top u_pw_sniffer_top (
      .fe_clk      (fe_clk),
      .rst_n_i     (rst_n),
      .arm_i       (arm),
      .cfg_i       (cfg),
      .fe_rx_i     (fe_rx),
      .trig_o      (trig),
      .capturing_o (capturing),
      .cap_valid_o (cap_valid),
      .cap_rec_o   (cap_rec)
   );

   initial begin
      fe_clk = 1'b0;
      forever #10 fe_clk = ~fe_clk;
   end

   always @(posedge fe_clk)
      cyc <= cyc + 1;

   // every record, with the cycle it showed up in
   always @(negedge fe_clk) begin
      if (cap_valid === 1'b1) begin
         got_q.push_back(cap_rec);
         got_cyc_q.push_back(cyc);
      end
   end

   //////////////////////////////
   // compare tasks
   //////////////////////////////

   task automatic check_bit(input string what, input logic got, input logic exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("[ERROR] t=%0t %s: got %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      chk_cnt++;
      if (got != exp) begin
         err_cnt++;
         $display("[ERROR] t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_rec(input int idx, input cap_rec_t got, input cap_rec_t exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("[ERROR] t=%0t record %0d: got time %0d data %h err %b, expected %0d %h %b",
                  $time, idx, got.timestamp, got.data, got.err,
                  exp.timestamp, exp.data, exp.err);
      end
   endtask

   task automatic report_timeout(input string what);
      err_cnt++;
      $display("timeout: waited %0d cycles for %s, it never happened", WAIT_MAX, what);
   endtask

   //////////////////////////////
   // driver
   //////////////////////////////

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge fe_clk);
   endtask

   task automatic setup_cfg(input pattern_t mask, input int nbytes, input int delay,
                            input int width, input int cap_len);
      cfg.pattern       = {$urandom, $urandom};
      cfg.mask          = mask;
      cfg.pattern_bytes = pat_cnt_t'(nbytes);
      cfg.trig_delay    = trig_delay_t'(delay);
      cfg.trig_width    = trig_width_t'(width);
      cfg.cap_len       = cap_len_t'(cap_len);
   endtask

   // pattern bytes under the mask, random everywhere else
   task automatic build_packet(input int len);
      fe_byte_t m;
      fe_byte_t p;
      for (int i = 0; i < len; i++) begin
         if (i < int'(cfg.pattern_bytes)) begin
            m = cfg.mask[i*8 +: 8];
            p = cfg.pattern[i*8 +: 8];
         end else begin
            m = 8'h00;
            p = 8'h00;
         end
         pkt_byte[i] = (p & m) | (fe_byte_t'($urandom) & ~m);
         pkt_err[i]  = 1'b0;
      end
   endtask

   // byte taken at edge k is recorded with time k - arm_edge - 1
   task automatic expect_record(input int k, input fe_byte_t d, input logic e);
      cap_rec_t r;
      int       t;
      if (model_armed && k > arm_edge && model_recs < int'(cfg.cap_len)) begin
         t           = k - arm_edge - 1;
         r.timestamp = (t > 65535) ? 16'hffff : timestamp_t'(t);
         r.data      = d;
         r.err       = e;
         exp_q.push_back(r);
         exp_cyc_q.push_back(k + 1);
         model_recs++;
      end
   endtask

   task automatic send_packet(input int len, input int pat_len);
      int k;
      for (int i = 0; i < len; i++) begin
         @(negedge fe_clk);
         fe_rx.data     = pkt_byte[i];
         fe_rx.rxvalid  = 1'b1;
         fe_rx.rxactive = 1'b1;
         fe_rx.rxerror  = pkt_err[i];
         k = cyc + 1; // edge that takes this byte
         if (i == pat_len - 1)
            last_pat_edge = k;
         expect_record(k, pkt_byte[i], pkt_err[i]);
      end
      @(negedge fe_clk);
      fe_rx = '0; // end of packet
   endtask

   task automatic set_arm(input logic level);
      int n;
      int edge_no;
      @(negedge fe_clk);
      arm         = level;
      edge_no     = cyc + 1;
      model_armed = level;
      if (level) begin
         arm_edge   = edge_no;
         model_recs = 0;
         exp_q.delete();
         exp_cyc_q.delete();
         got_q.delete();
         got_cyc_q.delete();
      end
      n = 0;
      while (capturing !== level && n < WAIT_MAX) begin
         @(negedge fe_clk);
         n++;
      end
      if (capturing !== level)
         report_timeout("capturing_o to follow arm_i");
      else
         check_count("capturing_o latency", cyc - edge_no, 0);
   endtask

   `include "tb_pw_sniffer_tests.svh"

   initial begin
      void'($urandom(9));
      err_cnt       = 0;
      chk_cnt       = 0;
      rst_n         = 1'b0;
      arm           = 1'b0;
      cfg           = '0;
      fe_rx         = '0;
      model_armed   = 1'b0;
      arm_edge      = 0;
      model_recs    = 0;
      last_pat_edge = 0;
      repeat (2) @(posedge fe_clk);
      @(negedge fe_clk);
      rst_n = 1'b1;

      test_reset_arm();
      test_trigger_timing();
      test_mask_error();
      test_one_per_arm();
      test_capture();

      $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* pw_sniffer.f */
+incdir+verification
design/pw_usb_pkg.sv
design/pw_trig_pkg.sv
design/pw_pattern_matcher.sv
design/pw_fe_capture.sv
design/pw_trigger_timer.sv
design/pw_trigger_fsm.sv
design/pw_sniffer_top.sv
verification/tb_pw_sniffer.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sniffer testbench with Verilator
# the run fails when the log holds the fail message

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_pw_sniffer \
   -f pw_sniffer.f -o sim_pw_sniffer > "$LOG" 2>&1 &&
./obj_dir/sim_pw_sniffer >> "$LOG" 2>&1 ||
{ echo "build or simulation error, see $LOG"; exit 1; }

grep -q "CHECKS FAILED" "$LOG" && { echo "simulation reported errors, see $LOG"; exit 1; } ||
echo "simulation clean, see $LOG"
